//--- src/soqpsk_defs.svh
// SOQPSK detector widths
`ifndef SOQPSK_DEFS_SVH
`define SOQPSK_DEFS_SVH

// ------------------------------------------------------------
// Datapath widths
// ------------------------------------------------------------

// Sample and coefficient width, Q1.17 signed
`define SOQPSK_SAMPLE_W 18

// Fraction bits dropped after an 18x18 multiply
`define SOQPSK_PROD_FRAC 17

// Integrator width
// Two half-symbol samples plus the branch difference
`define SOQPSK_ACC_W 20

`endif

//--- src/soqpskArithPkg.sv
// SOQPSK fixed-point helpers
package soqpskArithPkg;
   `include "soqpsk_defs.svh"

   // Sample range limits
   localparam logic signed [`SOQPSK_SAMPLE_W-1:0] SAMPLE_MAX =
      {1'b0, {(`SOQPSK_SAMPLE_W-1){1'b1}}};
   localparam logic signed [`SOQPSK_SAMPLE_W-1:0] SAMPLE_MIN =
      {1'b1, {(`SOQPSK_SAMPLE_W-1){1'b0}}};

   // ------------------------------------------------------------
   // Product scaling
   // ------------------------------------------------------------

   // Drop the product fraction, then clip to sample width
   function automatic logic signed [`SOQPSK_SAMPLE_W-1:0] scaleProduct(
      input logic signed [2*`SOQPSK_SAMPLE_W-1:0] prod
   );
      logic signed [2*`SOQPSK_SAMPLE_W-1:0] shifted;
      shifted = prod >>> `SOQPSK_PROD_FRAC;
      // In range when all bits above the sample sign agree with it
      if (&shifted[2*`SOQPSK_SAMPLE_W-1:`SOQPSK_SAMPLE_W-1] ||
          ~|shifted[2*`SOQPSK_SAMPLE_W-1:`SOQPSK_SAMPLE_W-1]) begin
         return $signed(shifted[`SOQPSK_SAMPLE_W-1:0]);
      end
      return shifted[2*`SOQPSK_SAMPLE_W-1] ? SAMPLE_MIN : SAMPLE_MAX;
   endfunction

   // ------------------------------------------------------------
   // Accumulator saturation
   // ------------------------------------------------------------
   function automatic logic signed [`SOQPSK_SAMPLE_W-1:0] satToSample(
      input logic signed [`SOQPSK_ACC_W-1:0] acc
   );
      // Same sign-bit test over the integrator guard bits
      if (&acc[`SOQPSK_ACC_W-1:`SOQPSK_SAMPLE_W-1] ||
          ~|acc[`SOQPSK_ACC_W-1:`SOQPSK_SAMPLE_W-1]) begin
         return $signed(acc[`SOQPSK_SAMPLE_W-1:0]);
      end
      return acc[`SOQPSK_ACC_W-1] ? SAMPLE_MIN : SAMPLE_MAX;
   endfunction

endpackage

//--- src/soqpskCoefPkg.sv
// SOQPSK hypothesis coefficients
package soqpskCoefPkg;
   `include "soqpsk_defs.svh"

   // 0.707 in Q1.17, rounded
   localparam logic signed [`SOQPSK_SAMPLE_W-1:0] COEF_MAG = 18'sd92668;

   // ------------------------------------------------------------
   // Hypothesis A, phase +45 degrees
   // ------------------------------------------------------------
   localparam logic signed [`SOQPSK_SAMPLE_W-1:0] COEF_A_RE = COEF_MAG;
   localparam logic signed [`SOQPSK_SAMPLE_W-1:0] COEF_A_IM = COEF_MAG;

   // ------------------------------------------------------------
   // Hypothesis B, phase -45 degrees
   // ------------------------------------------------------------
   localparam logic signed [`SOQPSK_SAMPLE_W-1:0] COEF_B_RE = COEF_MAG;
   // Conjugate of A
   localparam logic signed [`SOQPSK_SAMPLE_W-1:0] COEF_B_IM = -COEF_MAG;

endpackage

//--- src/cmpy18WithCe.sv
// Clock-enabled complex multiplier
`timescale 1ns/1ps
`include "soqpsk_defs.svh"

module cmpy18WithCe (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                ce,
   input  logic signed [`SOQPSK_SAMPLE_W-1:0]  aReal,
   input  logic signed [`SOQPSK_SAMPLE_W-1:0]  aImag,
   input  logic signed [`SOQPSK_SAMPLE_W-1:0]  bReal,
   input  logic signed [`SOQPSK_SAMPLE_W-1:0]  bImag,
   output logic signed [`SOQPSK_SAMPLE_W-1:0]  pReal,
   output logic signed [`SOQPSK_SAMPLE_W-1:0]  pImag
);
   import soqpskArithPkg::*;

   // Full product width
   localparam int PW = 2 * `SOQPSK_SAMPLE_W;

   // ------------------------------------------------------------
   // Partial products
   // ------------------------------------------------------------
   logic signed [PW-1:0] prodRR;
   logic signed [PW-1:0] prodII;
   logic signed [PW-1:0] prodRI;
   logic signed [PW-1:0] prodIR;

   // Unscaled real and imaginary parts
   logic signed [PW-1:0] sumReal;
   logic signed [PW-1:0] sumImag;

   // Operands sign-extended before multiply
   assign prodRR = PW'(aReal) * PW'(bReal);
   assign prodII = PW'(aImag) * PW'(bImag);
   assign prodRI = PW'(aReal) * PW'(bImag);
   assign prodIR = PW'(aImag) * PW'(bReal);

   // (a + jb)(c + jd) = (ac - bd) + j(ad + bc)
   // Coefficients below full scale keep these in range
   assign sumReal = prodRR - prodII;
   assign sumImag = prodRI + prodIR;

   // ------------------------------------------------------------
   // Scaled output register
   // ------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         pReal <= '0;
         pImag <= '0;
      end else if (ce) begin
         // Back to Q1.17, clipped
         pReal <= scaleProduct(sumReal);
         pImag <= scaleProduct(sumImag);
      end
   end

endmodule

//--- src/soqpskMfilter.sv
// SOQPSK one-tap matched filter
`timescale 1ns/1ps
`include "soqpsk_defs.svh"

module soqpskMfilter #(
   // Tap coefficient, set per hypothesis
   parameter logic signed [`SOQPSK_SAMPLE_W-1:0] reC = '0,
   parameter logic signed [`SOQPSK_SAMPLE_W-1:0] imC = '0
) (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                sym2xEn,
   input  logic signed [`SOQPSK_SAMPLE_W-1:0]  iIn,
   input  logic signed [`SOQPSK_SAMPLE_W-1:0]  qIn,
   output logic signed [`SOQPSK_SAMPLE_W-1:0]  iOut,
   output logic signed [`SOQPSK_SAMPLE_W-1:0]  qOut
);

   // Multiplier output, one strobe behind the input
   logic signed [`SOQPSK_SAMPLE_W-1:0] iMult;
   logic signed [`SOQPSK_SAMPLE_W-1:0] qMult;

   // ------------------------------------------------------------
   // Sample times coefficient
   // ------------------------------------------------------------
   cmpy18WithCe u_cmpMult (
      .clk   (clk),
      .rst   (rst),
      .ce    (sym2xEn),
      .aReal (iIn),
      .aImag (qIn),
      .bReal (reC),
      .bImag (imC),
      .pReal (iMult),
      .pImag (qMult)
   );

   // ------------------------------------------------------------
   // Output latch
   // ------------------------------------------------------------
   // Two strobes of latency from iIn/qIn to iOut/qOut
   always_ff @(posedge clk) begin
      if (rst) begin
         iOut <= '0;
         qOut <= '0;
      end else if (sym2xEn) begin
         iOut <= iMult;
         qOut <= qMult;
      end
   end

endmodule

//--- src/soqpskMfCombiner.sv
// SOQPSK branch combiner and decision
`timescale 1ns/1ps
`include "soqpsk_defs.svh"

module soqpskMfCombiner (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                sym2xEn,
   input  logic                                symEn,
   // Real outputs of the two matched filters
   input  logic signed [`SOQPSK_SAMPLE_W-1:0]  aI,
   input  logic signed [`SOQPSK_SAMPLE_W-1:0]  bI,
   output logic                                bitOut,
   output logic signed [`SOQPSK_SAMPLE_W-1:0]  metric,
   output logic                                symValid
);
   import soqpskArithPkg::*;

   localparam int AW = `SOQPSK_ACC_W;

   // ------------------------------------------------------------
   // Strobe decode
   // ------------------------------------------------------------
   logic symStrobe;
   logic halfStrobe;

   // symEn only counts together with sym2xEn
   assign symStrobe  = sym2xEn & symEn;
   // First half-symbol sample
   assign halfStrobe = sym2xEn & ~symEn;

   // ------------------------------------------------------------
   // First-half storage
   // ------------------------------------------------------------
   logic signed [`SOQPSK_SAMPLE_W-1:0] firstA;
   logic signed [`SOQPSK_SAMPLE_W-1:0] firstB;

   always_ff @(posedge clk) begin
      if (rst) begin
         firstA <= '0;
         firstB <= '0;
      end else if (halfStrobe) begin
         firstA <= aI;
         firstB <= bI;
      end
   end

   // ------------------------------------------------------------
   // Full-symbol sums
   // ------------------------------------------------------------
   logic signed [AW-1:0] sumA;
   logic signed [AW-1:0] sumB;
   logic signed [AW-1:0] sumDiff;

   // Sign-extended into integrator width
   assign sumA = AW'(aI) + AW'(firstA);
   assign sumB = AW'(bI) + AW'(firstB);

   // Fits in AW bits, both sums span 19 bits
   assign sumDiff = sumA - sumB;

   // ------------------------------------------------------------
   // Decision and soft metric
   // ------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (symStrobe) begin
         // Hard bit, 1 favors hypothesis A
         bitOut <= (sumA > sumB);
         // Soft metric, clipped to sample width
         metric <= satToSample(sumDiff);
      end
   end

   // One-cycle valid, aligned with the new bitOut and metric
   always_ff @(posedge clk) begin
      if (rst) begin
         symValid <= 1'b0;
      end else begin
         symValid <= symStrobe;
      end
   end

endmodule

//--- src/soqpskDetector.sv
// SOQPSK symbol detector top
`timescale 1ns/1ps
`include "soqpsk_defs.svh"

module soqpskDetector #(
   // Hypothesis A tap
   parameter logic signed [`SOQPSK_SAMPLE_W-1:0] coefARe = soqpskCoefPkg::COEF_A_RE,
   parameter logic signed [`SOQPSK_SAMPLE_W-1:0] coefAIm = soqpskCoefPkg::COEF_A_IM,
   // Hypothesis B tap
   parameter logic signed [`SOQPSK_SAMPLE_W-1:0] coefBRe = soqpskCoefPkg::COEF_B_RE,
   parameter logic signed [`SOQPSK_SAMPLE_W-1:0] coefBIm = soqpskCoefPkg::COEF_B_IM
) (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                sym2xEn,
   input  logic                                symEn,
   input  logic signed [`SOQPSK_SAMPLE_W-1:0]  iIn,
   input  logic signed [`SOQPSK_SAMPLE_W-1:0]  qIn,
   output logic                                bitOut,
   output logic signed [`SOQPSK_SAMPLE_W-1:0]  metric,
   output logic                                symValid
);

   // Real filter outputs, one per hypothesis
   logic signed [`SOQPSK_SAMPLE_W-1:0] mfARe;
   logic signed [`SOQPSK_SAMPLE_W-1:0] mfBRe;

   // ------------------------------------------------------------
   // Matched filters
   // ------------------------------------------------------------
   // Imaginary outputs unused, no quadrature decision here
   soqpskMfilter #(.reC(coefARe), .imC(coefAIm)) u_mfA (
      .clk     (clk),
      .rst     (rst),
      .sym2xEn (sym2xEn),
      .iIn     (iIn),
      .qIn     (qIn),
      .iOut    (mfARe),
      .qOut    ()
   );

   soqpskMfilter #(.reC(coefBRe), .imC(coefBIm)) u_mfB (
      .clk     (clk),
      .rst     (rst),
      .sym2xEn (sym2xEn),
      .iIn     (iIn),
      .qIn     (qIn),
      .iOut    (mfBRe),
      .qOut    ()
   );

   // ------------------------------------------------------------
   // Integrate and decide
   // ------------------------------------------------------------
   soqpskMfCombiner u_combiner (
      .clk      (clk),
      .rst      (rst),
      .sym2xEn  (sym2xEn),
      .symEn    (symEn),
      .aI       (mfARe),
      .bI       (mfBRe),
      .bitOut   (bitOut),
      .metric   (metric),
      .symValid (symValid)
   );

endmodule

//--- verif/soqpskDetectorTb.sv
// SOQPSK detector testbench
`timescale 1ns/1ps
`include "soqpsk_defs.svh"

module soqpskDetectorTb;

   localparam int SW             = `SOQPSK_SAMPLE_W;
   localparam int NUM_SAMPLES    = 64;
   localparam int NUM_SYMS       = 32;
   localparam int TIMEOUT_CYCLES = 2000;

   // ------------------------------------------------------------
   // DUT signals
   // ------------------------------------------------------------
   logic                 clk;
   logic                 rst;
   logic                 sym2xEn;
   logic                 symEn;
   logic signed [SW-1:0] iIn;
   logic signed [SW-1:0] qIn;
   logic                 bitOut;
   logic signed [SW-1:0] metric;
   logic                 symValid;

   // Raw pattern image, samples first, then expected symbols
   logic [39:0]          patternMem [0:NUM_SAMPLES+NUM_SYMS-1];

   // Unpacked stimulus and expected results
   logic signed [SW-1:0] sampleI   [0:NUM_SAMPLES-1];
   logic signed [SW-1:0] sampleQ   [0:NUM_SAMPLES-1];
   logic                 expBit    [0:NUM_SYMS-1];
   logic signed [SW-1:0] expMetric [0:NUM_SYMS-1];

   integer seed;
   int     symCount;
   logic   monitorOn;
   // Symbol strobe seen by the DUT at the last edge
   logic   strobePrev;

   soqpskDetector u_soqpskDetector (
      .clk      (clk),
      .rst      (rst),
      .sym2xEn  (sym2xEn),
      .symEn    (symEn),
      .iIn      (iIn),
      .qIn      (qIn),
      .bitOut   (bitOut),
      .metric   (metric),
      .symValid (symValid)
   );

   // 10 ns clock
   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // ------------------------------------------------------------
   // Checking helpers
   // ------------------------------------------------------------
   task automatic checkValue(input string testName,
                             input logic signed [31:0] expected,
                             input logic signed [31:0] actual);
      if (expected !== actual) begin
         $display("CHECK FAILED %s expected %0d actual %0d", testName, expected, actual);
         $display("TESTBENCH FAILED");
         $fatal(1, "value mismatch in %s", testName);
      end
   endtask

   task automatic reportFailure(input string what);
      $display("ERROR: %s", what);
      $display("TESTBENCH FAILED");
      $fatal(1, "%s", what);
   endtask

   // ------------------------------------------------------------
   // Stimulus helpers
   // ------------------------------------------------------------
   // Inputs change 1 ns after the rising edge
   task automatic nextDriveSlot();
      @(posedge clk);
      #1;
   endtask

   task automatic loadPatterns();
      int k;
      $readmemh("verif/soqpsk_patterns.hex", patternMem);
      if ($isunknown(patternMem[0]) ||
          $isunknown(patternMem[NUM_SAMPLES+NUM_SYMS-1])) begin
         reportFailure("pattern file is missing or incomplete");
      end
      for (k = 0; k < NUM_SAMPLES; k++) begin
         sampleI[k] = patternMem[k][37:20];
         sampleQ[k] = patternMem[k][17:0];
      end
      for (k = 0; k < NUM_SYMS; k++) begin
         expBit[k]    = patternMem[NUM_SAMPLES+k][20];
         expMetric[k] = patternMem[NUM_SAMPLES+k][17:0];
      end
   endtask

   // Eight edges with rst high
   task automatic applyReset();
      int k;
      rst = 1'b1;
      for (k = 0; k < 8; k++) begin
         nextDriveSlot();
         // symValid must already be low during reset
         monitorOn = 1'b1;
      end
      rst = 1'b0;
   endtask

   // One strobe cycle then one idle cycle
   task automatic driveSample(input int n);
      logic [31:0] noise;
      nextDriveSlot();
      sym2xEn = 1'b1;
      // Odd strobes close a symbol
      symEn   = (n % 2) == 1;
      iIn     = sampleI[n];
      qIn     = sampleQ[n];
      nextDriveSlot();
      sym2xEn = 1'b0;
      symEn   = 1'b0;
      // Off-strobe noise, must not reach the filters
      noise   = $random(seed);
      iIn     = noise[SW-1:0];
      noise   = $random(seed);
      qIn     = noise[SW-1:0];
   endtask

   // ------------------------------------------------------------
   // Output monitor
   // ------------------------------------------------------------
   // Outputs are stable at the falling edge
   always @(negedge clk) begin
      logic validExp;
      if (monitorOn) begin
         validExp   = strobePrev;
         strobePrev = sym2xEn & symEn & ~rst;
         // One pulse per symbol strobe, none elsewhere
         checkValue("symValid pulse", 32'(validExp), 32'(symValid));
         if (symValid) begin
            checkValue($sformatf("symbol %0d bitOut", symCount),
                       32'(expBit[symCount]), 32'(bitOut));
            checkValue($sformatf("symbol %0d metric", symCount),
                       32'(expMetric[symCount]), 32'(metric));
            symCount++;
         end
      end
   end

   // ------------------------------------------------------------
   // Main sequence
   // ------------------------------------------------------------
   initial begin
      int n;
      int waitCycles;
      seed       = 67993;
      rst        = 1'b1;
      sym2xEn    = 1'b0;
      symEn      = 1'b0;
      iIn        = '0;
      qIn        = '0;
      monitorOn  = 1'b0;
      strobePrev = 1'b0;
      symCount   = 0;

      loadPatterns();
      applyReset();

      // Whole stream, A, B, full scale, then mixed
      for (n = 0; n < NUM_SAMPLES; n++) begin
         driveSample(n);
      end

      // Wait for the last symbol outputs
      waitCycles = 0;
      while (symCount < NUM_SYMS && waitCycles < TIMEOUT_CYCLES) begin
         @(posedge clk);
         waitCycles++;
      end

      if (symCount < NUM_SYMS) begin
         reportFailure("symbol outputs stopped arriving before all 32 symbols");
      end else begin
         // Idle tail, a stray symValid still fails
         for (n = 0; n < 10; n++) begin
            @(posedge clk);
         end
         $display("TESTBENCH PASSED");
         $finish;
      end
   end

endmodule

//--- filelist.f
+incdir+src
src/soqpskArithPkg.sv
src/soqpskCoefPkg.sv
src/cmpy18WithCe.sv
src/soqpskMfilter.sv
src/soqpskMfCombiner.sv
src/soqpskDetector.sv
verif/soqpskDetectorTb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the SOQPSK detector testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
   -f filelist.f --top-module soqpskDetectorTb \
   && ./obj_dir/VsoqpskDetectorTb | tee /dev/stderr \
      | grep "TESTBENCH PASSED" > /dev/null \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }

//--- verif/soqpsk_patterns.hex
// Words 0-63: one sample each, I in bits 37:20 and Q in bits 17:0, 5 hex digits per field
// Words 64-95: one symbol each, bitOut in bit 20 and metric in bits 17:0
// Sample values are multiples of 2^14, that is eighths of full scale
// Samples 0-15, A-leaning pairs for symbols 1-8
08000FC000 0C000F8000 04000FC000 08000F4000
00000F8000 04000F4000 0C00000000 10000FC000
FC000F8000 F8000F4000 04000F0000 08000F0000
00000FC000 0400000000 14000FC000 00000F4000
// Samples 16-31, B-leaning pairs for symbols 9-16
0800004000 0C00008000 0400004000 080000C000
0000008000 FC0000C000 F800004000 F400008000
0400010000 0800010000 0000004000 FC00000000
0C0000C000 F8000FC000 1000004000 0000000000
// Samples 32-39, full-scale pairs for symbols 17-20
1C000E0000 1C000E0000 E00001C000 E00001C000
E0000E0000 1C0001C000 E0000E0000 E0000E0000
// Samples 40-61, mixed pairs for symbols 21-31
// Samples 62-63 fall past the last symbol
0C000F8000 0400008000 F0000F0000 18000E8000
0800014000 F400004000 04000FC000 0400000000
EC00008000 100000C000 18000EC000 F8000E8000
00000FC000 0000008000 0C000F4000 08000FC000
FC00010000 E800008000 1400000000 EC000FC000
08000E4000 E4000FC000 0400004000 FC000FC000

@40
// Symbol 0 from the reset fill, then symbols 1-7
0000000000 0000110F7D 00001169FC 000011C47B
0000105A7F 000011C47B 000011FFFF 0000105A7F
// Symbols 8-15
00001169FC 00000EF083 00000E9604 00000E3B85
00000EF083 00000E0000 00000FA581 00000F4B02
// Symbols 16-23, saturation and tie cases
00000FA581 000011FFFF 00000E0000 0000100001
000011FFFF 0000000000 000011FFFF 00000E0000
// Symbols 24-31
0000105A7F 00000E3B85 000011FFFF 00000FA581
00001169FC 00000E0000 0000105A7F 000011FFFF
